// File: design/cache_bank_pkg.sv
package cache_bank_pkg;

    // word geometry
    localparam int WORD_BITS = 32;
    localparam int WORD_BYTES = WORD_BITS / 8;

    // line geometry
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS = WORD_BITS * WORDS_PER_LINE;
    localparam int LINE_BYTES = WORD_BYTES * WORDS_PER_LINE;

    // core side addresses words, memory side addresses lines
    localparam int ADDR_BITS = 16;
    localparam int WSEL_BITS = $clog2(WORDS_PER_LINE);
    localparam int LINE_ADDR_BITS = ADDR_BITS - WSEL_BITS;

    // default core tag width
    localparam int CORE_TAG_BITS = 8;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;

    typedef struct packed {
        logic rw;
        logic [ADDR_BITS-1:0] addr;
        logic [WORD_BYTES-1:0] byteen;
        word_t data;
        logic [CORE_TAG_BITS-1:0] tag;
    } core_req_t;

    typedef struct packed {
        word_t data;
        logic [CORE_TAG_BITS-1:0] tag;
    } core_rsp_t;

    // rw high for a write-through, low for a line fill request
    typedef struct packed {
        logic rw;
        logic [LINE_ADDR_BITS-1:0] addr;
        logic [LINE_BYTES-1:0] byteen;
        line_t data;
    } mem_req_t;

endpackage

// File: design/elastic_fifo.sv
`timescale 1ns/1ps

module elastic_fifo #(
    parameter int DEPTH = 4,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready,
    output logic     almost_full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;
    logic push;
    logic pop;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    assign in_ready = (count != CNT_BITS'(DEPTH));
    assign out_valid = (count != '0);
    // one slot or none left
    assign almost_full = (count >= CNT_BITS'(DEPTH - 1));
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: design/tag_store.sv
`timescale 1ns/1ps

module tag_store #(
    parameter int NUM_LINES = 16
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     stall,
    input  logic [cache_bank_pkg::LINE_ADDR_BITS-1:0] lookup_addr,
    output logic                                     hit,
    input  logic                                     fill,
    input  logic [cache_bank_pkg::LINE_ADDR_BITS-1:0] fill_addr
);
    import cache_bank_pkg::*;

    localparam int INDEX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS = LINE_ADDR_BITS - INDEX_BITS;

    logic [NUM_LINES-1:0] valid;
    logic [TAG_BITS-1:0] tags [NUM_LINES];
    logic [INDEX_BITS-1:0] lookup_index;
    logic [INDEX_BITS-1:0] fill_index;

    assign lookup_index = lookup_addr[INDEX_BITS-1:0];
    assign fill_index = fill_addr[INDEX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (fill && !stall) begin
            valid[fill_index] <= 1'b1;
        end
    end

    // tag write and registered compare
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (fill) begin
                tags[fill_index] <= fill_addr[LINE_ADDR_BITS-1:INDEX_BITS];
            end
            hit <= valid[lookup_index]
                && (tags[lookup_index] == lookup_addr[LINE_ADDR_BITS-1:INDEX_BITS]);
        end
    end

endmodule

// File: design/data_store.sv
`timescale 1ns/1ps

module data_store #(
    parameter int NUM_LINES = 16
) (
    input  logic                                      clk,
    input  logic                                      stall,
    input  logic [cache_bank_pkg::LINE_ADDR_BITS-1:0] addr,
    input  logic                                      write,
    input  logic [cache_bank_pkg::LINE_BYTES-1:0]     byteen,
    input  cache_bank_pkg::line_t                     wdata,
    output cache_bank_pkg::line_t                     rdata
);
    import cache_bank_pkg::*;

    localparam int INDEX_BITS = $clog2(NUM_LINES);

    line_t lines [NUM_LINES];
    logic [INDEX_BITS-1:0] index;

    // low line address bits pick the set, upper bits live in the tag store
    assign index = addr[INDEX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (!stall && write) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (byteen[b]) begin
                    lines[index][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // read returns the old line on a same-cycle write
    always_ff @(posedge clk) begin
        if (!stall) begin
            rdata <= lines[index];
        end
    end

endmodule

// File: design/bank_pipeline.sv
`timescale 1ns/1ps

module bank_pipeline #(
    parameter int NUM_LINES = 16,
    parameter int CORE_TAG_BITS = 8
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      creq_valid,
    input  logic                                      creq_rw,
    input  logic [cache_bank_pkg::ADDR_BITS-1:0]      creq_addr,
    input  logic [cache_bank_pkg::WORD_BYTES-1:0]     creq_byteen,
    input  cache_bank_pkg::word_t                     creq_data,
    input  logic [CORE_TAG_BITS-1:0]                  creq_tag,
    output logic                                      creq_ready,
    input  logic                                      mem_rsp_valid,
    input  cache_bank_pkg::line_t                     mem_rsp_data,
    output logic                                      mem_rsp_ready,
    output logic                                      crsq_valid,
    output cache_bank_pkg::word_t                     crsq_data,
    output logic [CORE_TAG_BITS-1:0]                  crsq_tag,
    input  logic                                      crsq_ready,
    output logic                                      mreq_valid,
    output logic                                      mreq_rw,
    output logic [cache_bank_pkg::LINE_ADDR_BITS-1:0] mreq_addr,
    output logic [cache_bank_pkg::LINE_BYTES-1:0]     mreq_byteen,
    output cache_bank_pkg::line_t                     mreq_data,
    input  logic                                      mreq_almost_full
);
    import cache_bank_pkg::*;

    logic stall;
    logic creq_fire;
    logic fill_fire;
    logic [ADDR_BITS-1:0] sel_addr;
    logic [LINE_BYTES-1:0] sel_byteen;
    line_t sel_data;

    logic valid_st0, fill_st0, rw_st0, hit_st0;
    logic [ADDR_BITS-1:0] addr_st0;
    logic [LINE_BYTES-1:0] byteen_st0;
    line_t data_st0;
    logic [CORE_TAG_BITS-1:0] tag_st0;

    logic valid_st1, fill_st1, rw_st1, hit_st1;
    logic [ADDR_BITS-1:0] addr_st1;
    logic [LINE_BYTES-1:0] byteen_st1;
    line_t data_st1;
    line_t rdata_st1;
    line_t rsp_line;
    logic [CORE_TAG_BITS-1:0] tag_st1;

    logic miss_valid;
    logic [ADDR_BITS-1:0] miss_addr;
    logic [CORE_TAG_BITS-1:0] miss_tag;
    logic read_miss_st0, write_st0, read_st1, miss_block;

    assign creq_fire = creq_valid && creq_ready;
    assign fill_fire = mem_rsp_valid && mem_rsp_ready;

    assign read_miss_st0 = valid_st0 && !fill_st0 && !rw_st0 && !hit_st0;
    assign write_st0 = valid_st0 && !fill_st0 && rw_st0;
    assign read_st1 = valid_st1 && !fill_st1 && !rw_st1;
    assign miss_block = miss_valid || read_miss_st0 || (read_st1 && !hit_st1);

    // fill only answers the pending miss, which also keeps core requests out
    assign mem_rsp_ready = mem_rsp_valid && miss_valid && !stall;
    // no more than one write-through may be queued ahead of a new request
    assign creq_ready = !miss_block && !stall && !mreq_almost_full
                     && !(write_st0 && mreq_valid);

    assign sel_addr = fill_fire ? miss_addr : creq_addr;
    assign sel_byteen = fill_fire ? '1
                      : LINE_BYTES'(creq_byteen) << (creq_addr[WSEL_BITS-1:0] * WORD_BYTES);
    assign sel_data = fill_fire ? mem_rsp_data : {WORDS_PER_LINE{creq_data}};

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_st0 <= 1'b0;
            valid_st1 <= 1'b0;
        end else if (!stall) begin
            valid_st0 <= creq_fire || fill_fire;
            valid_st1 <= valid_st0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fill_st0 <= fill_fire;
            rw_st0 <= creq_rw && !fill_fire;
            addr_st0 <= sel_addr;
            byteen_st0 <= sel_byteen;
            data_st0 <= sel_data;
            tag_st0 <= creq_tag;
            fill_st1 <= fill_st0;
            rw_st1 <= rw_st0;
            hit_st1 <= hit_st0;
            addr_st1 <= addr_st0;
            byteen_st1 <= byteen_st0;
            data_st1 <= data_st0;
            tag_st1 <= tag_st0;
        end
    end

    tag_store #(
        .NUM_LINES (NUM_LINES)
    ) tags (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .lookup_addr (sel_addr[ADDR_BITS-1:WSEL_BITS]),
        .hit         (hit_st0),
        .fill        (valid_st0 && fill_st0),
        .fill_addr   (addr_st0[ADDR_BITS-1:WSEL_BITS])
    );

    // hit is known in stage 0, so data writes land before the next lookup
    data_store #(
        .NUM_LINES (NUM_LINES)
    ) data (
        .clk    (clk),
        .stall  (stall),
        .addr   (addr_st0[ADDR_BITS-1:WSEL_BITS]),
        .write  (valid_st0 && (fill_st0 || (rw_st0 && hit_st0))),
        .byteen (byteen_st0),
        .wdata  (data_st0),
        .rdata  (rdata_st1)
    );

    // single outstanding read miss
    always_ff @(posedge clk) begin
        if (reset) begin
            miss_valid <= 1'b0;
        end else if (read_st1 && !hit_st1) begin
            miss_valid <= 1'b1;
        end else if (valid_st1 && fill_st1 && !stall) begin
            miss_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (read_st1 && !hit_st1) begin
            miss_addr <= addr_st1;
            miss_tag <= tag_st1;
        end
    end

    // fill answers from its own data, hit from the store
    assign rsp_line = fill_st1 ? data_st1 : rdata_st1;
    assign crsq_valid = (read_st1 && hit_st1) || (valid_st1 && fill_st1);
    assign crsq_data = rsp_line[addr_st1[WSEL_BITS-1:0] * WORD_BITS +: WORD_BITS];
    assign crsq_tag = fill_st1 ? miss_tag : tag_st1;
    assign stall = crsq_valid && !crsq_ready;

    assign mreq_valid = valid_st1 && !fill_st1 && (rw_st1 || !hit_st1);
    assign mreq_rw = rw_st1;
    assign mreq_addr = addr_st1[ADDR_BITS-1:WSEL_BITS];
    assign mreq_byteen = rw_st1 ? byteen_st1 : '1;
    assign mreq_data = data_st1;

endmodule

// File: design/cache_bank.sv
`timescale 1ns/1ps

module cache_bank #(
    parameter int NUM_LINES = 16,
    parameter int CORE_TAG_BITS = 8,
    parameter int CREQ_DEPTH = 4,
    parameter int CRSQ_DEPTH = 4,
    parameter int MREQ_DEPTH = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      core_req_valid,
    input  logic                                      core_req_rw,
    input  logic [cache_bank_pkg::ADDR_BITS-1:0]      core_req_addr,
    input  logic [cache_bank_pkg::WORD_BYTES-1:0]     core_req_byteen,
    input  cache_bank_pkg::word_t                     core_req_data,
    input  logic [CORE_TAG_BITS-1:0]                  core_req_tag,
    output logic                                      core_req_ready,
    output logic                                      core_rsp_valid,
    output cache_bank_pkg::word_t                     core_rsp_data,
    output logic [CORE_TAG_BITS-1:0]                  core_rsp_tag,
    input  logic                                      core_rsp_ready,
    output logic                                      mem_req_valid,
    output logic                                      mem_req_rw,
    output logic [cache_bank_pkg::LINE_ADDR_BITS-1:0] mem_req_addr,
    output logic [cache_bank_pkg::LINE_BYTES-1:0]     mem_req_byteen,
    output cache_bank_pkg::line_t                     mem_req_data,
    input  logic                                      mem_req_ready,
    input  logic                                      mem_rsp_valid,
    input  cache_bank_pkg::line_t                     mem_rsp_data,
    output logic                                      mem_rsp_ready
);
    import cache_bank_pkg::*;

    // core payloads sized by this bank's tag width
    typedef struct packed {
        logic rw;
        logic [ADDR_BITS-1:0] addr;
        logic [WORD_BYTES-1:0] byteen;
        word_t data;
        logic [CORE_TAG_BITS-1:0] tag;
    } core_req_t;

    typedef struct packed {
        word_t data;
        logic [CORE_TAG_BITS-1:0] tag;
    } core_rsp_t;

    core_req_t creq_in, creq_out;
    core_rsp_t crsq_in, crsq_out;
    mem_req_t mreq_in, mreq_out;
    logic creq_valid, creq_ready;
    logic crsq_valid, crsq_ready;
    logic mreq_valid, mreq_almost_full;

    assign creq_in = '{rw: core_req_rw, addr: core_req_addr, byteen: core_req_byteen,
                       data: core_req_data, tag: core_req_tag};
    assign core_rsp_data = crsq_out.data;
    assign core_rsp_tag = crsq_out.tag;
    assign mem_req_rw = mreq_out.rw;
    assign mem_req_addr = mreq_out.addr;
    assign mem_req_byteen = mreq_out.byteen;
    assign mem_req_data = mreq_out.data;

    elastic_fifo #(.DEPTH (CREQ_DEPTH), .payload_t (core_req_t)) core_req_queue (
        .clk (clk), .reset (reset),
        .in_valid (core_req_valid), .in_data (creq_in), .in_ready (core_req_ready),
        .out_valid (creq_valid), .out_data (creq_out), .out_ready (creq_ready),
        .almost_full ()
    );

    elastic_fifo #(.DEPTH (CRSQ_DEPTH), .payload_t (core_rsp_t)) core_rsp_queue (
        .clk (clk), .reset (reset),
        .in_valid (crsq_valid), .in_data (crsq_in), .in_ready (crsq_ready),
        .out_valid (core_rsp_valid), .out_data (crsq_out), .out_ready (core_rsp_ready),
        .almost_full ()
    );

    elastic_fifo #(.DEPTH (MREQ_DEPTH), .payload_t (mem_req_t)) mem_req_queue (
        .clk (clk), .reset (reset),
        .in_valid (mreq_valid), .in_data (mreq_in), .in_ready (),
        .out_valid (mem_req_valid), .out_data (mreq_out), .out_ready (mem_req_ready),
        .almost_full (mreq_almost_full)
    );

    bank_pipeline #(.NUM_LINES (NUM_LINES), .CORE_TAG_BITS (CORE_TAG_BITS)) pipeline (
        .clk (clk), .reset (reset),
        .creq_valid (creq_valid), .creq_rw (creq_out.rw), .creq_addr (creq_out.addr),
        .creq_byteen (creq_out.byteen), .creq_data (creq_out.data),
        .creq_tag (creq_out.tag), .creq_ready (creq_ready),
        .mem_rsp_valid (mem_rsp_valid), .mem_rsp_data (mem_rsp_data),
        .mem_rsp_ready (mem_rsp_ready),
        .crsq_valid (crsq_valid), .crsq_data (crsq_in.data), .crsq_tag (crsq_in.tag),
        .crsq_ready (crsq_ready),
        .mreq_valid (mreq_valid), .mreq_rw (mreq_in.rw), .mreq_addr (mreq_in.addr),
        .mreq_byteen (mreq_in.byteen), .mreq_data (mreq_in.data),
        .mreq_almost_full (mreq_almost_full)
    );

endmodule

// File: tb/cache_bank_assert.sv
`timescale 1ns/1ps

module cache_bank_assert (
    input logic         clk,
    input logic         reset,
    input logic         core_rsp_valid,
    input logic         core_rsp_ready,
    input logic [31:0]  core_rsp_data,
    input logic [7:0]   core_rsp_tag,
    input logic         mem_req_valid,
    input logic         mem_req_ready,
    input logic         mem_req_rw,
    input logic [13:0]  mem_req_addr,
    input logic [15:0]  mem_req_byteen,
    input logic [127:0] mem_req_data,
    input logic         mem_rsp_valid,
    input logic         mem_rsp_ready
);

    // memory reads accepted but not yet answered
    logic [3:0] reads_open;
    int failures = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            reads_open <= '0;
        end else begin
            reads_open <= reads_open
                + 4'(mem_req_valid && mem_req_ready && !mem_req_rw)
                - 4'(mem_rsp_valid && mem_rsp_ready);
        end
    end

    rsp_stable: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid && !core_rsp_ready |=>
            core_rsp_valid && $stable(core_rsp_data) && $stable(core_rsp_tag))
        else begin
            failures++;
            $error("core response changed while stalled");
        end

    mreq_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_rw) && $stable(mem_req_addr)
            && $stable(mem_req_byteen) && $stable(mem_req_data))
        else begin
            failures++;
            $error("memory request changed while stalled");
        end

    mreq_after_reset: assert property (@(posedge clk) $fell(reset) |-> !mem_req_valid)
        else begin
            failures++;
            $error("memory request valid right after reset");
        end

    rsp_ready_open: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_ready |-> reads_open != 0)
        else begin
            failures++;
            $error("memory response accepted with no read outstanding");
        end

endmodule

// File: tb/cache_bank_tb.sv
`timescale 1ns/1ps

module cache_bank_tb;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS = 6;
    localparam int WAIT_CYCLES = 200;

    logic clk = 0;
    logic reset;
    logic core_req_valid, core_req_rw, core_req_ready;
    logic [15:0] core_req_addr;
    logic [3:0] core_req_byteen;
    logic [31:0] core_req_data;
    logic [7:0] core_req_tag;
    logic core_rsp_valid, core_rsp_ready;
    logic [31:0] core_rsp_data;
    logic [7:0] core_rsp_tag;
    logic mem_req_valid, mem_req_rw, mem_req_ready;
    logic [13:0] mem_req_addr;
    logic [15:0] mem_req_byteen;
    logic [127:0] mem_req_data;
    logic mem_rsp_valid, mem_rsp_ready;
    logic [127:0] mem_rsp_data;

    // memory model state
    logic [127:0] lines [16384];
    int mem_reads = 0;
    int mem_writes = 0;
    logic [13:0] last_wr_addr;
    logic [15:0] last_wr_byteen;
    logic [13:0] last_rd_addr;
    logic [15:0] last_rd_byteen;
    logic [31:0] rnd_state = 32'd89;

    cache_bank UUT (.*);

    bind cache_bank cache_bank_assert checker_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rnd_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rnd_state = x;
        return x;
    endfunction

    function automatic logic [31:0] model_word(logic [15:0] addr);
        return lines[addr[15:2]][addr[1:0]*32 +: 32];
    endfunction

    task automatic stop_run(string what);
        $display("%s at %0t", what, $time);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // memory side, sampled before the edge and driven 1 ns after it
    always begin : memory_model
        int delay;
        logic req, fire, rw;
        logic [13:0] addr;
        logic [15:0] be;
        logic [127:0] data;
        logic [13:0] rd_line;
        delay = 0;
        forever begin
            @(negedge clk);
            req = mem_req_valid && mem_req_ready;
            fire = mem_rsp_valid && mem_rsp_ready;
            rw = mem_req_rw;
            addr = mem_req_addr;
            be = mem_req_byteen;
            data = mem_req_data;
            @(posedge clk);
            #1;
            if (req && rw) begin
                for (int b = 0; b < 16; b++) begin
                    if (be[b]) lines[addr][b*8 +: 8] = data[b*8 +: 8];
                end
                mem_writes++;
                last_wr_addr = addr;
                last_wr_byteen = be;
            end else if (req) begin
                mem_reads++;
                last_rd_addr = addr;
                last_rd_byteen = be;
                rd_line = addr;
                delay = 3;
            end
            if (fire) mem_rsp_valid = 1'b0;
            if (delay > 0) begin
                delay--;
                if (delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data = lines[rd_line];
                end
            end
        end
    end

    // bound assertions count their failures
    always @(negedge clk) begin
        if (UUT.checker_inst.failures != 0) begin
            stop_run("a bound assertion failed");
        end
    end

    task automatic send_req(logic rw, logic [15:0] addr, logic [3:0] be, logic [31:0] data,
                            logic [7:0] tag);
        logic rdy;
        int n;
        core_req_valid = 1'b1;
        core_req_rw = rw;
        core_req_addr = addr;
        core_req_byteen = be;
        core_req_data = data;
        core_req_tag = tag;
        n = 0;
        do begin
            @(negedge clk);
            rdy = core_req_ready;
            @(posedge clk);
            if (++n > WAIT_CYCLES) stop_run("core request never accepted");
        end while (!rdy);
        #1 core_req_valid = 1'b0;
    endtask

    task automatic do_read(logic [15:0] addr, logic [7:0] tag, int exp_mem_reads);
        int r0, n;
        r0 = mem_reads;
        send_req(1'b0, addr, 4'h0, 32'h0, tag);
        n = 0;
        do begin
            @(negedge clk);
            if (++n > WAIT_CYCLES) stop_run("no core response arrived");
        end while (!core_rsp_valid);
        check_val("core_rsp_tag", core_rsp_tag, tag);
        check_val("core_rsp_data", core_rsp_data, model_word(addr));
        @(posedge clk);
        check_val("memory reads", mem_reads - r0, exp_mem_reads);
        // a fill asks for the whole line
        if (exp_mem_reads != 0) begin
            check_val("mem_req_addr", last_rd_addr, addr[15:2]);
            check_val("mem_req_byteen", last_rd_byteen, 16'hFFFF);
        end
        #1;
    endtask

    task automatic do_write(logic [15:0] addr, logic [3:0] be, logic [31:0] data);
        logic [31:0] merged;
        logic [15:0] exp_be;
        int w0, r0, n;
        merged = model_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) merged[b*8 +: 8] = data[b*8 +: 8];
        end
        exp_be = '0;
        exp_be[addr[1:0]*4 +: 4] = be;
        w0 = mem_writes;
        r0 = mem_reads;
        send_req(1'b1, addr, be, data, 8'h00);
        n = 0;
        while (mem_writes == w0) begin
            @(negedge clk);
            if (++n > WAIT_CYCLES) stop_run("write-through never reached memory");
        end
        check_val("memory writes", mem_writes - w0, 1);
        check_val("memory reads", mem_reads - r0, 0);
        check_val("mem_req_addr", last_wr_addr, addr[15:2]);
        check_val("mem_req_byteen", last_wr_byteen, exp_be);
        check_val("memory word", model_word(addr), merged);
        @(posedge clk);
        #1;
    endtask

    task automatic stream_reads();
        logic [7:0] tags [$];
        logic [15:0] addrs [$];
        logic [31:0] r;
        int got;
        got = 0;
        fork
            for (int i = 0; i < 32; i++) begin
                addrs.push_back(16'h0400 + 16'(i));
                tags.push_back(8'(8'h80 + i));
                send_req(1'b0, 16'h0400 + 16'(i), 4'h0, 32'h0, 8'(8'h80 + i));
            end
            while (got < 32) begin
                @(negedge clk);
                if (core_rsp_valid && core_rsp_ready) begin
                    check_val("core_rsp_tag", core_rsp_tag, tags.pop_front());
                    check_val("core_rsp_data", core_rsp_data, model_word(addrs.pop_front()));
                    got++;
                end
                @(posedge clk);
                #1;
                // stall both the core response and memory request channels
                r = xorshift();
                core_rsp_ready = r[0];
                mem_req_ready = r[1];
            end
        join
        core_rsp_ready = 1'b1;
        mem_req_ready = 1'b1;
    endtask

    initial begin : watchdog
        #(NUM_TESTS * WAIT_CYCLES * CLK_PERIOD);
        stop_run("simulation timed out");
    end

    initial begin
        for (int a = 0; a < 16384; a++) begin
            lines[a] = {xorshift(), xorshift(), xorshift(), xorshift()} ^ 128'(a);
        end
        reset = 1'b1;
        core_req_valid = 1'b0;
        core_req_rw = 1'b0;
        core_req_addr = '0;
        core_req_byteen = '0;
        core_req_data = '0;
        core_req_tag = '0;
        core_rsp_ready = 1'b1;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        // read miss and fill, then a hit in the same line
        do_read(16'h0100, 8'h11, 1);
        do_read(16'h0102, 8'h12, 0);
        // write hit merges into the cached word
        do_write(16'h0101, 4'b0101, 32'hA5C3_3C5A);
        do_read(16'h0101, 8'h13, 0);
        // write miss does not allocate
        do_write(16'h0214, 4'b1111, 32'h1234_5678);
        do_read(16'h0214, 8'h14, 1);
        // same index, different tag
        do_read(16'h0328, 8'h15, 1);
        do_read(16'h0728, 8'h16, 1);
        do_read(16'h0328, 8'h17, 1);
        stream_reads();

        if (UUT.checker_inst.failures == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_run("a bound assertion failed");
        end
    end

endmodule

// File: verilog.f
design/cache_bank_pkg.sv
design/elastic_fifo.sv
design/tag_store.sv
design/data_store.sv
design/bank_pipeline.sv
design/cache_bank.sv
tb/cache_bank_assert.sv
tb/cache_bank_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module cache_bank_tb -Mdir obj_dir
	./obj_dir/Vcache_bank_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; \
	elif grep -q "Test passed" $(LOG); then echo "PASS"; \
	else echo "FAIL"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
